// File: verilog/fe_bus_pkg.sv
package fe_bus_pkg;

	// ====================
	// bus widths
	// ====================

	// byte address of the instruction bus
	localparam int W_ADDR = 32;

	// bus data width
	// the frontend only handles a full 32-bit data path
	localparam int W_DATA = 32;

	// ====================
	// address phase size
	// ====================

	// mem_size is one bit wide
	// a word access is the normal case
	localparam logic SIZE_WORD = 1'b1;

	// halfword access, used only for the first fetch after a jump to
	// an odd halfword target
	localparam logic SIZE_HALF = 1'b0;

	// ====================
	// pipelining limits
	// ====================

	// most fetches in flight at once
	// one in the data phase plus one held in the address phase
	localparam int MAX_PENDING = 2;

	// width of the outstanding and drop counters
	localparam int W_PEND = $clog2(MAX_PENDING + 1);

endpackage

// File: verilog/fe_instr_pkg.sv
package fe_instr_pkg;

	// ====================
	// halfword bundles
	// ====================

	// one 16-bit parcel, the unit that compressed instructions are built from
	typedef logic [fe_bus_pkg::W_DATA/2-1:0] hw_t;

	// one fetched bus word
	// the queue moves it as a whole word
	// assembly picks it apart as two halfwords, half[0] is the lower address
	typedef union packed {
		logic [fe_bus_pkg::W_DATA-1:0] word;
		hw_t [1:0]                     half;
	} fetch_word_u;

	// ====================
	// CIR level encoding
	// ====================

	// width of cir_vld, cir_use and the internal buffer level
	localparam int LEVEL_W = 2;

	// halfword counts
	// the buffer can hold three, decode sees at most two
	localparam logic [LEVEL_W-1:0] LVL_NONE  = 2'd0;
	localparam logic [LEVEL_W-1:0] LVL_ONE   = 2'd1;
	localparam logic [LEVEL_W-1:0] LVL_TWO   = 2'd2;
	// two in the CIR plus the spare halfword
	localparam logic [LEVEL_W-1:0] LVL_THREE = 2'd3;

endpackage

// File: verilog/fetch_request.sv
module fetch_request #(
	parameter int                              FIFO_DEPTH   = 2,
	parameter logic [fe_bus_pkg::W_ADDR-1:0]   RESET_VECTOR = '0
) (
	input  logic                               clk,
	input  logic                               rst_n,
	// address phase
	output logic [fe_bus_pkg::W_ADDR-1:0]      mem_addr,
	output logic                               mem_size,
	output logic                               mem_addr_vld,
	input  logic                               mem_addr_rdy,
	// data phase, strobe only
	input  logic                               mem_data_vld,
	// jump request from the core
	input  logic [fe_bus_pkg::W_ADDR-1:0]      jump_target,
	input  logic                               jump_target_vld,
	output logic                               jump_target_rdy,
	// queue status
	input  logic                               q_full,
	input  logic                               q_almost_full,
	// to queue and assembly
	output logic                               flush,
	output logic                               data_keep,
	output logic                               unaligned_dph
);

	localparam int W_PEND = fe_bus_pkg::W_PEND;
	// a shallow queue cannot absorb more fetches than it has slots
	localparam int PEND_LIMIT = (FIFO_DEPTH < fe_bus_pkg::MAX_PENDING) ?
		FIFO_DEPTH : fe_bus_pkg::MAX_PENDING;

	logic                        addr_hold;
	logic [W_PEND-1:0]           pending;
	logic [W_PEND-1:0]           pending_next;
	logic [W_PEND-1:0]           drop_cnt;
	logic [fe_bus_pkg::W_ADDR-1:0] fetch_addr;
	logic                        fetch_stall;
	logic                        unaligned_now;
	logic                        unaligned_aph;

	// ====================
	// bus bookkeeping
	// ====================

	// a request counts once, in the cycle it is first presented
	assign pending_next = pending + W_PEND'(mem_addr_vld && !addr_hold)
		- W_PEND'(mem_data_vld);

	// jumps can only go out when nothing is being held on the bus
	assign jump_target_rdy = !addr_hold;
	assign flush = jump_target_vld && jump_target_rdy;

	// words still owed from before a jump are dropped here
	assign data_keep = mem_data_vld && (drop_cnt == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_hold <= 1'b0;
			pending <= '0;
			drop_cnt <= '0;
		end else begin
			addr_hold <= mem_addr_vld && !mem_addr_rdy;
			pending <= pending_next;
			if (flush) begin
				// everything in flight except the jump fetch itself
				drop_cnt <= pending_next - W_PEND'(1);
			end else if (drop_cnt != '0 && mem_data_vld) begin
				drop_cnt <= drop_cnt - W_PEND'(1);
			end
		end
	end

	// fetch address runs ahead of decode in whole words
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= RESET_VECTOR;
		end else if (flush) begin
			// skip past the target word if it went out this cycle
			fetch_addr <= {jump_target[fe_bus_pkg::W_ADDR-1:2]
				+ (fe_bus_pkg::W_ADDR-2)'(mem_addr_rdy), 2'b00};
		end else if (mem_addr_vld && mem_addr_rdy) begin
			fetch_addr <= fetch_addr + fe_bus_pkg::W_ADDR'(4);
		end
	end

	// registered inputs only, keeps hready off the address path
	assign fetch_stall = q_full
		|| (q_almost_full && pending != '0)
		|| pending >= W_PEND'(PEND_LIMIT);

	// ====================
	// unaligned jumps
	// ====================

	// aph flags a held halfword request, dph flags the word that answers it
	assign unaligned_now = flush && jump_target[1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			unaligned_aph <= 1'b0;
			unaligned_dph <= 1'b0;
		end else begin
			if (mem_addr_rdy)
				unaligned_aph <= 1'b0;
			if (data_keep)
				unaligned_dph <= 1'b0;
			// a new jump wins over the clears above
			// an aligned one also cancels an odd target still in flight
			if (flush) begin
				unaligned_aph <= unaligned_now && !mem_addr_rdy;
				unaligned_dph <= unaligned_now;
			end
		end
	end

	// ====================
	// address phase request
	// ====================

	always_comb begin
		mem_addr = fetch_addr;
		mem_size = fe_bus_pkg::SIZE_WORD;
		mem_addr_vld = 1'b1;
		if (addr_hold) begin
			// replay the held request unchanged
			mem_addr = {fetch_addr[fe_bus_pkg::W_ADDR-1:2], unaligned_aph, 1'b0};
			mem_size = unaligned_aph ? fe_bus_pkg::SIZE_HALF : fe_bus_pkg::SIZE_WORD;
		end else if (jump_target_vld) begin
			mem_addr = jump_target;
			mem_size = unaligned_now ? fe_bus_pkg::SIZE_HALF : fe_bus_pkg::SIZE_WORD;
		end else if (fetch_stall) begin
			mem_addr_vld = 1'b0;
		end
	end

	a_pending_max: assert property (@(posedge clk) disable iff (!rst_n)
		pending <= W_PEND'(fe_bus_pkg::MAX_PENDING));

	a_drop_le_pending: assert property (@(posedge clk) disable iff (!rst_n)
		drop_cnt <= pending);

endmodule

// File: verilog/fetch_queue.sv
module fetch_queue #(
	parameter int FIFO_DEPTH = 2
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      push,
	input  fe_instr_pkg::fetch_word_u wdata,
	input  logic                      pop,
	input  logic                      flush,
	output fe_instr_pkg::fetch_word_u rdata,
	output logic                      empty,
	output logic                      full,
	output logic                      almost_full
);

	// extra pointer bit tells full from empty
	localparam int W_PTR = $clog2(FIFO_DEPTH) + 1;
	localparam int W_IDX = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam logic [W_PTR-1:0] IDX_MASK = W_PTR'(FIFO_DEPTH - 1);

	fe_instr_pkg::fetch_word_u mem [FIFO_DEPTH];

	logic [W_PTR-1:0] wptr;
	logic [W_PTR-1:0] rptr;
	logic [W_PTR-1:0] level;
	logic [W_IDX-1:0] wr_idx;
	logic [W_IDX-1:0] rd_idx;

	// ====================
	// status
	// ====================

	assign level = wptr - rptr;
	assign empty = (level == '0);
	assign full = (level == W_PTR'(FIFO_DEPTH));
	assign almost_full = (level == W_PTR'(FIFO_DEPTH - 1));

	assign wr_idx = W_IDX'(wptr & IDX_MASK);
	assign rd_idx = W_IDX'(rptr & IDX_MASK);

	// ====================
	// pointers and storage
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push)
				wptr <= wptr + W_PTR'(1);
			if (flush) begin
				// drop all buffered words, the one arriving now included
				rptr <= wptr + W_PTR'(push);
			end else if (pop) begin
				rptr <= rptr + W_PTR'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_idx] <= wdata;
	end

	// head word falls through, valid whenever not empty
	assign rdata = mem[rd_idx];

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		!(push && full));

	// popping an empty queue is only legal as a bypass of the word pushed now
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		(pop && empty) |-> push);

endmodule

// File: verilog/instr_assembly.sv
module instr_assembly (
	input  logic                                 clk,
	input  logic                                 rst_n,
	// queue head
	input  fe_instr_pkg::fetch_word_u            q_rdata,
	input  logic                                 q_empty,
	output logic                                 q_pop,
	// live bus data and the controls that qualify it
	input  logic [fe_bus_pkg::W_DATA-1:0]        mem_data,
	input  logic                                 data_keep,
	input  logic                                 flush,
	input  logic                                 unaligned_dph,
	// decode side
	output logic [fe_bus_pkg::W_DATA-1:0]        cir,
	output logic [fe_instr_pkg::LEVEL_W-1:0]     cir_vld,
	input  logic [fe_instr_pkg::LEVEL_W-1:0]     cir_use
);

	localparam int LEVEL_W = fe_instr_pkg::LEVEL_W;

	// halfwords held in {hwbuf, cir}, 0 to 3
	logic [LEVEL_W-1:0]        level;
	logic [LEVEL_W-1:0]        level_used;
	logic [LEVEL_W-1:0]        level_next;
	fe_instr_pkg::hw_t         hwbuf;
	fe_instr_pkg::hw_t [2:0]   held;
	fe_instr_pkg::hw_t [2:0]   shifted;
	fe_instr_pkg::hw_t [2:0]   merged;
	fe_instr_pkg::fetch_word_u fetch_word;
	logic                      fetch_vld;
	logic                      take;

	// ====================
	// recycle
	// ====================

	// slot 0 is the oldest halfword
	assign held = {hwbuf, cir};

	// drop what decode consumed this cycle
	// slots above the remaining level are don't care
	always_comb begin
		case (cir_use)
			fe_instr_pkg::LVL_ONE: shifted = {hwbuf, hwbuf, held[1]};
			fe_instr_pkg::LVL_TWO: shifted = {hwbuf, hwbuf, hwbuf};
			default:               shifted = held;
		endcase
	end

	assign level_used = level - cir_use;

	// ====================
	// fresh data
	// ====================

	// queue has the older word, the bus only counts once it has drained
	assign fetch_word = q_empty ? fe_instr_pkg::fetch_word_u'(mem_data) : q_rdata;
	assign fetch_vld = !q_empty || data_keep;

	// a whole word fits when at most one halfword stays behind
	// first word after an odd jump only brings one halfword, level is 0 then
	assign take = !flush && fetch_vld && (unaligned_dph || !level_used[1]);
	assign q_pop = take;

	// overlay the fetched halfwords just above what is left
	always_comb begin
		merged = shifted;
		if (unaligned_dph) begin
			// target is the upper half of the word
			merged[0] = fetch_word.half[1];
		end else if (level_used == fe_instr_pkg::LVL_ONE) begin
			merged[2:1] = fetch_word.half;
		end else if (level_used == fe_instr_pkg::LVL_NONE) begin
			merged[1:0] = fetch_word.half;
		end
	end

	// flush empties the buffer
	// dropped words never get here since data_keep is low and the queue was flushed
	always_comb begin
		if (flush)
			level_next = fe_instr_pkg::LVL_NONE;
		else if (take && unaligned_dph)
			level_next = fe_instr_pkg::LVL_ONE;
		else if (take)
			level_next = level_used + fe_instr_pkg::LVL_TWO;
		else
			level_next = level_used;
	end

	// ====================
	// CIR registers
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			level <= fe_instr_pkg::LVL_NONE;
		else
			level <= level_next;
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= merged;
	end

	// spare halfword stays hidden from decode
	assign cir_vld = (level == fe_instr_pkg::LVL_THREE) ? fe_instr_pkg::LVL_TWO : level;

	a_use_le_vld: assert property (@(posedge clk) disable iff (!rst_n)
		cir_use <= cir_vld);

	// the word answering an odd jump lands in an empty buffer
	a_odd_target_empty: assert property (@(posedge clk) disable iff (!rst_n)
		(take && unaligned_dph) |-> level_used == fe_instr_pkg::LVL_NONE);

endmodule

// File: verilog/frontend_top.sv
module frontend_top #(
	// queue depth, power of two
	parameter int                            FIFO_DEPTH   = 2,
	// first fetch address after reset
	parameter logic [fe_bus_pkg::W_ADDR-1:0] RESET_VECTOR = '0
) (
	input  logic                             clk,
	input  logic                             rst_n,

	// instruction bus, address phase
	output logic [fe_bus_pkg::W_ADDR-1:0]    mem_addr,
	output logic                             mem_size,
	output logic                             mem_addr_vld,
	input  logic                             mem_addr_rdy,

	// instruction bus, data phase
	input  logic [fe_bus_pkg::W_DATA-1:0]    mem_data,
	input  logic                             mem_data_vld,

	// jump and flush
	input  logic [fe_bus_pkg::W_ADDR-1:0]    jump_target,
	input  logic                             jump_target_vld,
	output logic                             jump_target_rdy,

	// decode
	output logic [fe_bus_pkg::W_DATA-1:0]    cir,
	output logic [fe_instr_pkg::LEVEL_W-1:0] cir_vld,
	input  logic [fe_instr_pkg::LEVEL_W-1:0] cir_use
);

	// ====================
	// internal wiring
	// ====================

	logic                      flush;
	logic                      data_keep;
	logic                      unaligned_dph;
	logic                      q_full;
	logic                      q_almost_full;
	logic                      q_empty;
	logic                      q_pop;
	fe_instr_pkg::fetch_word_u q_rdata;

	// address generation and in-flight tracking
	fetch_request #(
		.FIFO_DEPTH   (FIFO_DEPTH),
		.RESET_VECTOR (RESET_VECTOR)
	) u_fetch_request (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_size        (mem_size),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.q_full          (q_full),
		.q_almost_full   (q_almost_full),
		.flush           (flush),
		.data_keep       (data_keep),
		.unaligned_dph   (unaligned_dph)
	);

	// every kept bus word is pushed, assembly may bypass it straight away
	fetch_queue #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fetch_queue (
		.clk         (clk),
		.rst_n       (rst_n),
		.push        (data_keep),
		.wdata       (mem_data),
		.pop         (q_pop),
		.flush       (flush),
		.rdata       (q_rdata),
		.empty       (q_empty),
		.full        (q_full),
		.almost_full (q_almost_full)
	);

	instr_assembly u_instr_assembly (
		.clk           (clk),
		.rst_n         (rst_n),
		.q_rdata       (q_rdata),
		.q_empty       (q_empty),
		.q_pop         (q_pop),
		.mem_data      (mem_data),
		.data_keep     (data_keep),
		.flush         (flush),
		.unaligned_dph (unaligned_dph),
		.cir           (cir),
		.cir_vld       (cir_vld),
		.cir_use       (cir_use)
	);

endmodule

// File: dv/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// ====================
// random numbers
// ====================

// galois lfsr, x^32 + x^22 + x^2 + x + 1
// one step per random bit
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0000_0000);
endfunction

// ====================
// memory content
// ====================

// fixed hash of the word address
// halfword low bits come out random, so roughly one in four is a 32-bit opcode
function automatic logic [31:0] mem_word(input logic [31:0] addr);
	logic [31:0] h;
	h = {2'b00, addr[31:2]} * 32'h9e37_79b1;
	h = h ^ (h >> 15);
	h = h * 32'h85eb_ca6b;
	h = h ^ (h >> 13);
	return h;
endfunction

// one parcel, addr[1] picks the upper half of the word
function automatic logic [15:0] halfword_at(input logic [31:0] addr);
	logic [31:0] w;
	w = mem_word({addr[31:2], 2'b00});
	return addr[1] ? w[31:16] : w[15:0];
endfunction

// ====================
// reference
// ====================

// the two parcels decode should see at pc, oldest in the low half
function automatic logic [31:0] expected_instr(input logic [31:0] pc);
	return {halfword_at(pc + 32'd2), halfword_at(pc)};
endfunction

// 32-bit instructions have both low opcode bits set
function automatic int instr_len(input logic [31:0] pc);
	logic [15:0] hw;
	hw = halfword_at(pc);
	return (hw[1:0] == 2'b11) ? 2 : 1;
endfunction

`endif

// File: dv/tb_frontend.sv
module tb_frontend;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int FIFO_DEPTH = 2;
	localparam logic [fe_bus_pkg::W_ADDR-1:0] RESET_VECTOR = 32'h0000_1000;
	localparam int N_INSTR = 400;
	// worst case budget per decoded instruction
	localparam int TIMEOUT_CYCLES = N_INSTR * 20;

	`include "tb_ref.svh"

	logic                             clk;
	logic                             rst_n;
	logic [fe_bus_pkg::W_ADDR-1:0]    mem_addr;
	logic                             mem_size;
	logic                             mem_addr_vld;
	logic                             mem_addr_rdy;
	logic [fe_bus_pkg::W_DATA-1:0]    mem_data;
	logic                             mem_data_vld;
	logic [fe_bus_pkg::W_ADDR-1:0]    jump_target;
	logic                             jump_target_vld;
	logic                             jump_target_rdy;
	logic [fe_bus_pkg::W_DATA-1:0]    cir;
	logic [fe_instr_pkg::LEVEL_W-1:0] cir_vld;
	logic [fe_instr_pkg::LEVEL_W-1:0] cir_use;

	// memory model, one data phase behind the address phase
	logic        dph_vld;
	logic [31:0] dph_addr;
	// request seen without mem_addr_rdy in the previous cycle
	logic        held_vld;
	logic [31:0] held_addr;
	logic        held_size;
	// decode model
	logic [31:0] pc;
	logic        jump_accepted;
	logic        clear_due;
	logic [31:0] lfsr_state;
	int          decoded;
	int          jumps;
	int          cycles;
	int          mismatch_cnt;
	int          protocol_cnt;
	int          timeout_cnt;

	frontend_top #(
		.FIFO_DEPTH   (FIFO_DEPTH),
		.RESET_VECTOR (RESET_VECTOR)
	) DUT (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_size        (mem_size),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.cir             (cir),
		.cir_vld         (cir_vld),
		.cir_use         (cir_use)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// takes n bits from the lfsr, newest bit lowest
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int          k;
		v = '0;
		for (k = 0; k < n; k++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	// ====================
	// end of cycle
	// ====================

	// runs just before the rising edge, the values here are what the DUT takes
	task automatic sample_cycle();
		logic exp_size;
		if (held_vld) begin
			assert (mem_addr_vld && mem_addr == held_addr && mem_size == held_size) else begin
				protocol_cnt++;
				$display("%0t: address phase request changed before mem_addr_rdy", $time);
			end
			// no jump may slip in while the bus still owes the held request
			assert (!jump_target_rdy) else begin
				protocol_cnt++;
				$display("%0t: jump_target_rdy high while a request is held", $time);
			end
		end
		if (mem_addr_vld) begin
			// only the fetch of an odd jump target is a halfword access
			exp_size = mem_addr[1] ? fe_bus_pkg::SIZE_HALF : fe_bus_pkg::SIZE_WORD;
			assert (mem_size == exp_size) else begin
				mismatch_cnt++;
				$display("MISMATCH %0t: request to %h has size %b, expected %b",
					$time, mem_addr, mem_size, exp_size);
			end
		end
		held_vld = mem_addr_vld && !mem_addr_rdy;
		held_addr = mem_addr;
		held_size = mem_size;
		// hready ends the data phase and accepts the next address together
		if (mem_addr_rdy) begin
			dph_vld = mem_addr_vld;
			dph_addr = mem_addr;
		end
		clear_due = 1'b0;
		if (jump_target_vld && jump_target_rdy) begin
			pc = jump_target;
			jump_accepted = 1'b1;
			clear_due = 1'b1;
			jumps++;
		end else if (cir_use != '0) begin
			pc = pc + {29'd0, cir_use, 1'b0};
			decoded++;
		end
	endtask

	// ====================
	// start of cycle
	// ====================

	task automatic drive_inputs();
		logic [31:0] rnd;
		int          len;
		// one hready for both bus phases, low one cycle in four
		rnd = rand_bits(2);
		mem_addr_rdy = (rnd[1:0] != 2'b00);
		mem_data_vld = mem_addr_rdy && dph_vld;
		// junk on the data lines whenever they are not valid
		mem_data = mem_data_vld ? mem_word(dph_addr) : ~mem_word(dph_addr);
		if (jump_accepted) begin
			jump_target_vld = 1'b0;
			jump_accepted = 1'b0;
		end
		// new jump now and then, held until jump_target_rdy
		if (!jump_target_vld) begin
			rnd = rand_bits(5);
			if (rnd[4:0] == 5'd0) begin
				rnd = rand_bits(15);
				jump_target = {16'h0002, rnd[14:0], 1'b0};
				jump_target_vld = 1'b1;
			end
		end
		// decode waits for the whole instruction, stalls at random
		// and takes nothing while a jump is pending
		len = instr_len(pc);
		rnd = rand_bits(2);
		if (jump_target_vld || rnd[1:0] == 2'b00 || int'(cir_vld) < len)
			cir_use = '0;
		else
			cir_use = fe_instr_pkg::LEVEL_W'(len);
	endtask

	// ====================
	// compare
	// ====================

	// mid cycle, after the edge updates and the input drive
	always @(negedge clk) begin : compare_cir
		logic [31:0] exp_instr;
		int          i;
		if (rst_n) begin
			exp_instr = expected_instr(pc);
			if (clear_due) begin
				assert (cir_vld == '0) else begin
					mismatch_cnt++;
					$display("MISMATCH %0t: cir_vld %0d one cycle after a jump, expected 0",
						$time, cir_vld);
				end
			end
			for (i = 0; i < 2; i++) begin
				if (i < int'(cir_vld)) begin
					assert (cir[16*i +: 16] == exp_instr[16*i +: 16]) else begin
						mismatch_cnt++;
						$display("MISMATCH %0t: pc %h halfword %0d got %h expected %h",
							$time, pc, i, cir[16*i +: 16], exp_instr[16*i +: 16]);
					end
				end
			end
		end
	end

	// ====================
	// main sequence
	// ====================

	initial begin
		rst_n = 1'b0;
		mem_addr_rdy = 1'b0;
		mem_data_vld = 1'b0;
		mem_data = '0;
		jump_target = '0;
		jump_target_vld = 1'b0;
		cir_use = '0;
		dph_vld = 1'b0;
		dph_addr = '0;
		held_vld = 1'b0;
		held_addr = '0;
		held_size = 1'b0;
		pc = RESET_VECTOR;
		jump_accepted = 1'b0;
		clear_due = 1'b0;
		lfsr_state = 32'hc103;
		decoded = 0;
		jumps = 0;
		cycles = 0;
		mismatch_cnt = 0;
		protocol_cnt = 0;
		timeout_cnt = 0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// fetching starts at the reset vector with an empty CIR
		assert (cir_vld == '0 && mem_addr_vld && mem_addr == RESET_VECTOR) else begin
			mismatch_cnt++;
			$display("MISMATCH %0t: after reset cir_vld %0d mem_addr_vld %b mem_addr %h",
				$time, cir_vld, mem_addr_vld, mem_addr);
		end
		drive_inputs();
		while (decoded < N_INSTR && cycles < TIMEOUT_CYCLES) begin
			#6;
			sample_cycle();
			@(posedge clk);
			cycles++;
			#1;
			drive_inputs();
		end
		if (decoded < N_INSTR) begin
			timeout_cnt++;
			$display("timeout after %0d cycles, only %0d of %0d instructions decoded",
				cycles, decoded, N_INSTR);
		end
		$display("decoded %0d, jumps %0d, mismatches %0d, protocol errors %0d, timeouts %0d",
			decoded, jumps, mismatch_cnt, protocol_cnt, timeout_cnt);
		if (mismatch_cnt == 0 && protocol_cnt == 0 && timeout_cnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+dv
verilog/fe_bus_pkg.sv
verilog/fe_instr_pkg.sv
verilog/fetch_request.sv
verilog/fetch_queue.sv
verilog/instr_assembly.sv
verilog/frontend_top.sv
dv/tb_frontend.sv

// File: run.sh
#!/bin/sh
# build the frontend testbench with Verilator, run it, judge the log

rm -f sim.log \
	&& verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_frontend -Mdir obj_dir -o tb_frontend -f compile.f \
	&& { ./obj_dir/tb_frontend > sim.log 2>&1 || true; } \
	&& cat sim.log \
	&& ! grep -q "Done: errors found" sim.log \
	&& grep -q "Done: no errors" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
